//--- common/panel_pkg.sv
// Types shared by the front panel display subsystem.
// The major state codes are 5 bits wide and appear unchanged in the top
// five bits of the state word display, so their order is fixed.
// Only F0..F3, D0..D3, E0..E3 and H0 are reached by the sequencer here.

package panel_pkg;

    // major states of the processor, grouped by class
    typedef enum logic [4:0] {
        // fetch
        DB0,
        DB1,
        F0,
        FW,
        F1,
        F2,
        F3,
        F2A,
        F2B,
        // defer
        D0,
        DW,
        D1,
        D2,
        D3,
        // execute
        E0,
        EW,
        E1,
        E2,
        E3,
        EAE0,
        EAE1,
        // halt
        H0,
        H1
    } major_state_e;

    // positions of the display selector, in button rotation order
    typedef enum logic [2:0] {
        DISP_STATE,
        DISP_STATE1,
        DISP_STATUS,
        DISP_AC,
        DISP_MB,
        DISP_MQ,
        DISP_BUS
    } disp_pos_e;

endpackage

//--- common/panel_regs_if.sv
// Major state and register snapshot seen by the display multiplexer.
// All words use bit 0 as the most significant bit.
// state1 keeps the word indices 3..11 it occupies on the display, holding
// the instruction register bits 0..2 then six cycle flags.
// The top level drives everything except state, which the sequencer owns.

`timescale 1ns/10ps

`include "panel_settings.svh"

interface panel_regs_if;

    panel_pkg::major_state_e     state;
    logic [3:`PANEL_WORD_W-1]    state1;
    logic [0:`PANEL_WORD_W-1]    status;
    logic [0:`PANEL_WORD_W-1]    ac;
    logic [0:`PANEL_WORD_W-1]    mb;
    logic [0:`PANEL_WORD_W-1]    mq;
    logic [0:`PANEL_WORD_W-1]    io_bus;

    // the sequencer only writes the major state
    modport seq (
        output state
    );

    // the display side reads the whole snapshot
    modport view (
        input state,
        input state1,
        input status,
        input ac,
        input mb,
        input mq,
        input io_bus
    );

endinterface

//--- common/panel_settings.svh
// Sizing macros shared by the front panel display subsystem.
// Word and select widths follow the PDP-8/e panel, where bit 0 of a word
// is the most significant bit. The lamp pattern width stays fixed at 5.
// A synchronizer depth below 2 is not supported by display_select.

`ifndef PANEL_SETTINGS_SVH
`define PANEL_SETTINGS_SVH

// width of every displayed word and of each panel register
`define PANEL_WORD_W 12

// one-hot select lines from the display selector to the multiplexer
// (the state word position has no line of its own)
`define PANEL_NUM_SEL 6

// flip-flops in the push-button synchronizer chain
`define PANEL_SYNC_STAGES 2

`endif

//--- dv/panel_properties.sv
// Concurrent checks on the major state, the display select and the
// readout handshake, attached to panel_top with bind.
// All checks are off while reset is high.

`timescale 1ns/10ps

`include "panel_settings.svh"

module panel_properties (
    input logic                      clk,
    input logic                      reset,
    input logic                      req,
    input logic                      ack,
    input logic [0:`PANEL_NUM_SEL-1] dsel,
    input panel_pkg::major_state_e   state
);

    // ack may only drop once the host has let go of req
    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    // H1 is the last code of the enum
    state_legal: assert property (@(posedge clk) disable iff (reset)
        state <= panel_pkg::H1)
        else $error("major state is outside the enum");

    dsel_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(dsel))
        else $error("display select has more than one line set");

endmodule

//--- dv/panel_tb.sv
// Directed testbench for the front panel display subsystem.
// Expected words come from a model of the display table and the major
// state rule. Inputs change on the falling edge and outputs are sampled there.
// Every wait is bounded, so a stuck DUT shows up as failed checks.

`timescale 1ns/10ps

`include "panel_settings.svh"

module panel_tb;

    logic                     clk;
    logic                     reset;
    logic                     start, halt_sw, cycle_strobe, defer_need, exec_need;
    logic                     button, sw_active, req, run_led, ack;
    logic [0:2]               ir;
    logic [0:5]               cycle_flags;
    logic [0:`PANEL_WORD_W-1] status, ac, mb, mq, io_bus, dout, read_word, held_word, tmp;
    logic [0:4]               dsel_led, read_led;
    logic [31:0]              rng_state;
    int                       checks;
    int                       errors;
    panel_pkg::major_state_e  m_state;
    panel_pkg::disp_pos_e     m_pos;

    panel_top dut (.*);

    bind panel_top panel_properties u_props (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .ack   (ack),
        .dsel  (dsel),
        .state (regs.state)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [0:`PANEL_WORD_W-1] rand_word();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[27:16];
    endfunction

    // FS, DS, ES, HS by the class grouping of the state codes
    function automatic logic [0:3] class_flags(input panel_pkg::major_state_e s);
        if (s <= panel_pkg::F2B) return 4'b1000;
        if (s <= panel_pkg::D3) return 4'b0100;
        if (s <= panel_pkg::EAE1) return 4'b0010;
        return 4'b0001;
    endfunction

    function automatic logic [0:`PANEL_WORD_W-1] expected_word(input panel_pkg::disp_pos_e pos);
        logic [0:3] f;
        f = class_flags(m_state);
        case (pos)
            panel_pkg::DISP_STATE1: return {f[0:2], ir, cycle_flags};
            panel_pkg::DISP_STATUS: return status;
            panel_pkg::DISP_AC:     return ac;
            panel_pkg::DISP_MB:     return mb;
            panel_pkg::DISP_MQ:     return mq;
            panel_pkg::DISP_BUS:    return io_bus;
            default:                return {m_state, f, 3'b000};
        endcase
    endfunction

    function automatic logic [0:4] expected_led(input panel_pkg::disp_pos_e pos);
        case (pos)
            panel_pkg::DISP_STATUS: return 5'b01010;
            panel_pkg::DISP_AC:     return 5'b01001;
            panel_pkg::DISP_MB:     return 5'b10100;
            panel_pkg::DISP_MQ:     return 5'b10010;
            panel_pkg::DISP_BUS:    return 5'b10001;
            default:                return 5'b01100;
        endcase
    endfunction

    // end of a major cycle is F3, D3 or E3, where halt_sw takes priority
    function automatic panel_pkg::major_state_e next_state(input panel_pkg::major_state_e s);
        case (s)
            panel_pkg::H0: return start ? panel_pkg::F0 : panel_pkg::H0;
            panel_pkg::F0: return panel_pkg::F1;
            panel_pkg::F1: return panel_pkg::F2;
            panel_pkg::F2: return panel_pkg::F3;
            panel_pkg::D0: return panel_pkg::D1;
            panel_pkg::D1: return panel_pkg::D2;
            panel_pkg::D2: return panel_pkg::D3;
            panel_pkg::E0: return panel_pkg::E1;
            panel_pkg::E1: return panel_pkg::E2;
            panel_pkg::E2: return panel_pkg::E3;
            default: begin
                if (halt_sw) return panel_pkg::H0;
                if (s == panel_pkg::F3 && defer_need) return panel_pkg::D0;
                if (s != panel_pkg::E3 && exec_need) return panel_pkg::E0;
                return panel_pkg::F0;
            end
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic wait_display(input string name, input panel_pkg::disp_pos_e pos);
        int n;
        n = 0;
        while ((dout !== expected_word(pos) || dsel_led !== expected_led(pos)) && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (n >= 10) $display("%s: display did not settle within 10 cycles", name);
        check_value({name, " dout"}, 32'(expected_word(pos)), 32'(dout));
        check_value({name, " dsel_led"}, 32'(expected_led(pos)), 32'(dsel_led));
    endtask

    task automatic wait_ack(input string name, input logic level);
        int n;
        n = 0;
        while (ack !== level && n < 10) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (ack === level) else begin
            errors++;
            $display("%s: ack did not reach %0b within 10 cycles", name, level);
        end
    endtask

    task automatic press_button(input string name);
        button = 1'b1;
        m_pos  = m_pos.next();
        @(negedge clk);
        wait_display(name, m_pos);
        button = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic step_cycle(input string name);
        m_state      = next_state(m_state);
        cycle_strobe = 1'b1;
        @(negedge clk);
        cycle_strobe = 1'b0;
        start        = 1'b0;
        wait_display(name, panel_pkg::DISP_STATE);
    endtask

    task automatic test_reset_display();
        wait_display("test_reset_display", panel_pkg::DISP_STATE);
        check_value("test_reset_display run_led", 32'd0, 32'(run_led));
        sw_active = 1'b1;
        @(negedge clk);
        check_value("test_reset_display run_led", 32'd1, 32'(run_led));
    endtask

    task automatic test_select_cycle();
        status = rand_word();
        ac     = rand_word();
        mb     = rand_word();
        mq     = rand_word();
        io_bus = rand_word();
        tmp    = rand_word();
        ir          = tmp[0:2];
        cycle_flags = tmp[3:8];
        repeat (7) press_button("test_select_cycle");
    endtask

    task automatic test_sequencer_paths();
        // with sw_active low a wrong halt would turn the run lamp off
        sw_active  = 1'b0;
        start      = 1'b1;
        defer_need = 1'b1;
        exec_need  = 1'b1;
        // H0, then F0..F3, D0..D3, E0..E3 and back to F0
        repeat (13) begin
            step_cycle("test_sequencer_paths");
            check_value("test_sequencer_paths run_led", 32'd1, 32'(run_led));
        end
    endtask

    task automatic test_halt();
        defer_need = 1'b0;
        sw_active  = 1'b0;
        repeat (6) step_cycle("test_halt");
        halt_sw = 1'b1;
        repeat (2) step_cycle("test_halt");
        halt_sw = 1'b0;
        check_value("test_halt hs", 32'd1, 32'(dout[8]));
        check_value("test_halt run_led", 32'd0, 32'(run_led));
    endtask

    task automatic test_readout_handshake();
        repeat (3) press_button("test_readout_handshake");
        held_word = ac;
        req       = 1'b1;
        wait_ack("test_readout_handshake", 1'b1);
        check_value("test_readout_handshake read_word", 32'(held_word), 32'(read_word));
        check_value("test_readout_handshake read_led", 32'(expected_led(m_pos)),
                    32'(read_led));
        // every bit of the new AC differs from the captured word
        ac = ~held_word;
        wait_display("test_readout_handshake", m_pos);
        check_value("test_readout_handshake held word", 32'(held_word), 32'(read_word));
        check_value("test_readout_handshake held ack", 32'd1, 32'(ack));
        req = 1'b0;
        wait_ack("test_readout_handshake", 1'b0);
    endtask

    initial begin
        rng_state    = 32'h5f7947a8;
        checks       = 0;
        errors       = 0;
        m_state      = panel_pkg::H0;
        m_pos        = panel_pkg::DISP_STATE;
        reset        = 1'b1;
        start        = 1'b0;
        halt_sw      = 1'b0;
        cycle_strobe = 1'b0;
        defer_need   = 1'b0;
        exec_need    = 1'b0;
        button       = 1'b0;
        sw_active    = 1'b0;
        req          = 1'b0;
        ir           = '0;
        cycle_flags  = '0;
        status       = '0;
        ac           = '0;
        mb           = '0;
        mq           = '0;
        io_bus       = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        test_reset_display();
        test_select_cycle();
        test_sequencer_paths();
        test_halt();
        test_readout_handshake();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- front_panel/display_mux.sv
// Display multiplexer for the front panel lamps.
// dout and dsel_led are registered, one clock behind dsel and the sources.
// run_led is combinational from the major state and sw_active.
// If several select lines are set, the highest index wins.
// Words use bit 0 as the most significant bit. A lamp lights when one of
// the first two pattern bits grounds it and one of the last three drives it.

`timescale 1ns/10ps

`include "panel_settings.svh"

module display_mux (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [0:`PANEL_NUM_SEL-1]   dsel,
    input  logic                        sw_active,
    panel_regs_if.view                  regs,
    output logic [0:`PANEL_WORD_W-1]    dout,
    output logic [0:4]                  dsel_led,
    output logic                        run_led
);

    logic fs;
    logic ds;
    logic es;
    logic hs;

    // class flags of the current major state
    always_comb begin
        fs      = 1'b0;
        ds      = 1'b0;
        es      = 1'b0;
        hs      = 1'b0;
        run_led = 1'b1;
        case (regs.state)
            panel_pkg::DB0, panel_pkg::DB1, panel_pkg::F0, panel_pkg::FW,
            panel_pkg::F1, panel_pkg::F2, panel_pkg::F3, panel_pkg::F2A,
            panel_pkg::F2B: fs = 1'b1;
            panel_pkg::D0, panel_pkg::DW, panel_pkg::D1, panel_pkg::D2,
            panel_pkg::D3: ds = 1'b1;
            panel_pkg::E0, panel_pkg::EW, panel_pkg::E1, panel_pkg::E2,
            panel_pkg::E3, panel_pkg::EAE0, panel_pkg::EAE1: es = 1'b1;
            default: begin
                // halt, and any code outside the enum, counts as halt
                hs      = 1'b1;
                run_led = sw_active;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // the halted state word is what the panel shows out of reset
            dout     <= {panel_pkg::H0, 4'b0001, 3'b000};
            dsel_led <= 5'b01100;
        end else if (dsel[5]) begin
            dout     <= {fs, ds, es, regs.state1};
            dsel_led <= 5'b01100;
        end else if (dsel[4]) begin
            dout     <= regs.status;
            dsel_led <= 5'b01010;
        end else if (dsel[3]) begin
            dout     <= regs.ac;
            dsel_led <= 5'b01001;
        end else if (dsel[2]) begin
            dout     <= regs.mb;
            dsel_led <= 5'b10100;
        end else if (dsel[1]) begin
            dout     <= regs.mq;
            dsel_led <= 5'b10010;
        end else if (dsel[0]) begin
            dout     <= regs.io_bus;
            dsel_led <= 5'b10001;
        end else begin
            dout     <= {regs.state, fs, ds, es, hs, 3'b000};
            dsel_led <= 5'b01100;
        end
    end

endmodule

//--- front_panel/display_select.sv
// Push-button display selector.
// The button is asynchronous and assumed debounced outside this block.
// A press shows up on dsel three clocks after the button rises, and each
// rising edge steps exactly one position.
// dsel is one-hot, or all zero for the state word position. Bit 0 of dsel
// is the most significant bit.

`timescale 1ns/10ps

`include "panel_settings.svh"

module display_select (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        button,
    output logic [0:`PANEL_NUM_SEL-1]   dsel
);

    logic [`PANEL_SYNC_STAGES-1:0] btn_sync;
    logic                          btn_prev;
    logic                          btn_rise;
    panel_pkg::disp_pos_e          pos;

    // the last sync stage is compared with its own delayed copy
    assign btn_rise = btn_sync[`PANEL_SYNC_STAGES-1] & ~btn_prev;

    always_ff @(posedge clk) begin
        if (reset) begin
            btn_sync <= '0;
            btn_prev <= 1'b0;
            pos      <= panel_pkg::DISP_STATE;
        end else begin
            btn_sync <= {btn_sync[`PANEL_SYNC_STAGES-2:0], button};
            btn_prev <= btn_sync[`PANEL_SYNC_STAGES-1];
            if (btn_rise) begin
                case (pos)
                    panel_pkg::DISP_STATE:  pos <= panel_pkg::DISP_STATE1;
                    panel_pkg::DISP_STATE1: pos <= panel_pkg::DISP_STATUS;
                    panel_pkg::DISP_STATUS: pos <= panel_pkg::DISP_AC;
                    panel_pkg::DISP_AC:     pos <= panel_pkg::DISP_MB;
                    panel_pkg::DISP_MB:     pos <= panel_pkg::DISP_MQ;
                    panel_pkg::DISP_MQ:     pos <= panel_pkg::DISP_BUS;
                    default:                pos <= panel_pkg::DISP_STATE;
                endcase
            end
        end
    end

    // rotation runs from dsel[5] down to dsel[0]
    always_comb begin
        dsel = '0;
        case (pos)
            panel_pkg::DISP_STATE1: dsel[5] = 1'b1;
            panel_pkg::DISP_STATUS: dsel[4] = 1'b1;
            panel_pkg::DISP_AC:     dsel[3] = 1'b1;
            panel_pkg::DISP_MB:     dsel[2] = 1'b1;
            panel_pkg::DISP_MQ:     dsel[1] = 1'b1;
            panel_pkg::DISP_BUS:    dsel[0] = 1'b1;
            default:                dsel    = '0;
        endcase
    end

endmodule

//--- front_panel/readout_port.sv
// Four-phase req/ack readout of the displayed word and lamp pattern.
// req passes through a single sync register, so the host is expected to
// run from this clock or a slow related one.
// ack rises two clocks after req rises and falls two clocks after req falls.
// The captured values hold for as long as req stays high.

`timescale 1ns/10ps

`include "panel_settings.svh"

module readout_port (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req,
    input  logic [0:`PANEL_WORD_W-1]    dout,
    input  logic [0:4]                  dsel_led,
    output logic                        ack,
    output logic [0:`PANEL_WORD_W-1]    read_word,
    output logic [0:4]                  read_led
);

    typedef enum logic {
        IDLE,
        HELD
    } port_state_e;

    port_state_e state;
    logic        req_sync;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_sync <= 1'b0;
            state    <= IDLE;
        end else begin
            req_sync <= req;
            case (state)
                IDLE: if (req_sync) state <= HELD;
                HELD: if (!req_sync) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // capture on the way into HELD only
    always_ff @(posedge clk) begin
        if (state == IDLE && req_sync) begin
            read_word <= dout;
            read_led  <= dsel_led;
        end
    end

    assign ack = (state == HELD);

endmodule

//--- run.sh
#!/bin/sh
# Builds the panel testbench with Verilator, runs it and checks the result.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module panel_tb -o panel_sim &&
./obj_dir/panel_sim | tee /dev/stderr | grep -q "All checks passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- src/major_state_seq.sv
// Major state sequencer for the panel model.
// The state moves only on clock edges with cycle_strobe high, and starting
// from H0 needs start and cycle_strobe on the same edge.
// halt_sw is looked at only on the last state of a major cycle (F3, D3, E3).
// States that are never entered here (FW, DB0, H1 and the like) fall back
// to H0 on the next strobe.

`timescale 1ns/10ps

module major_state_seq (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  logic      halt_sw,
    input  logic      cycle_strobe,
    input  logic      defer_need,
    input  logic      exec_need,
    panel_regs_if.seq regs
);

    panel_pkg::major_state_e state;
    panel_pkg::major_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            panel_pkg::H0: begin
                if (start) begin
                    state_next = panel_pkg::F0;
                end
            end
            panel_pkg::F0: state_next = panel_pkg::F1;
            panel_pkg::F1: state_next = panel_pkg::F2;
            panel_pkg::F2: state_next = panel_pkg::F3;
            panel_pkg::F3: begin
                // end of fetch decides between defer, execute and a new fetch
                if (halt_sw) begin
                    state_next = panel_pkg::H0;
                end else if (defer_need) begin
                    state_next = panel_pkg::D0;
                end else if (exec_need) begin
                    state_next = panel_pkg::E0;
                end else begin
                    state_next = panel_pkg::F0;
                end
            end
            panel_pkg::D0: state_next = panel_pkg::D1;
            panel_pkg::D1: state_next = panel_pkg::D2;
            panel_pkg::D2: state_next = panel_pkg::D3;
            panel_pkg::D3: begin
                if (halt_sw) begin
                    state_next = panel_pkg::H0;
                end else if (exec_need) begin
                    state_next = panel_pkg::E0;
                end else begin
                    state_next = panel_pkg::F0;
                end
            end
            panel_pkg::E0: state_next = panel_pkg::E1;
            panel_pkg::E1: state_next = panel_pkg::E2;
            panel_pkg::E2: state_next = panel_pkg::E3;
            panel_pkg::E3: begin
                state_next = halt_sw ? panel_pkg::H0 : panel_pkg::F0;
            end
            default: state_next = panel_pkg::H0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= panel_pkg::H0;
        end else if (cycle_strobe) begin
            state <= state_next;
        end
    end

    assign regs.state = state;

endmodule

//--- src/panel_top.sv
// Top level of the front panel display subsystem.
// Processor registers, instruction bits and cycle flags come in as plain
// inputs, since the datapath and memory are outside this design.
// All 12-bit words use bit 0 as the most significant bit.
// The major state sequencer only needs defer_need and exec_need to route.

`timescale 1ns/10ps

`include "panel_settings.svh"

module panel_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        halt_sw,
    input  logic                        cycle_strobe,
    input  logic                        defer_need,
    input  logic                        exec_need,
    input  logic                        button,
    input  logic                        sw_active,
    input  logic                        req,
    input  logic [0:2]                  ir,
    input  logic [0:5]                  cycle_flags,
    input  logic [0:`PANEL_WORD_W-1]    status,
    input  logic [0:`PANEL_WORD_W-1]    ac,
    input  logic [0:`PANEL_WORD_W-1]    mb,
    input  logic [0:`PANEL_WORD_W-1]    mq,
    input  logic [0:`PANEL_WORD_W-1]    io_bus,
    output logic [0:`PANEL_WORD_W-1]    dout,
    output logic [0:4]                  dsel_led,
    output logic                        run_led,
    output logic                        ack,
    output logic [0:`PANEL_WORD_W-1]    read_word,
    output logic [0:4]                  read_led
);

    logic [0:`PANEL_NUM_SEL-1] dsel;

    panel_regs_if regs ();

    // instruction bits lead the cycle flags in the state1 word
    assign regs.state1 = {ir, cycle_flags};
    assign regs.status = status;
    assign regs.ac     = ac;
    assign regs.mb     = mb;
    assign regs.mq     = mq;
    assign regs.io_bus = io_bus;

    major_state_seq u_seq (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .halt_sw      (halt_sw),
        .cycle_strobe (cycle_strobe),
        .defer_need   (defer_need),
        .exec_need    (exec_need),
        .regs         (regs.seq)
    );

    display_select u_select (
        .clk    (clk),
        .reset  (reset),
        .button (button),
        .dsel   (dsel)
    );

    display_mux u_mux (
        .clk       (clk),
        .reset     (reset),
        .dsel      (dsel),
        .sw_active (sw_active),
        .regs      (regs.view),
        .dout      (dout),
        .dsel_led  (dsel_led),
        .run_led   (run_led)
    );

    readout_port u_readout (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .dout      (dout),
        .dsel_led  (dsel_led),
        .ack       (ack),
        .read_word (read_word),
        .read_led  (read_led)
    );

endmodule

//--- vlog.f
+incdir+common
common/panel_pkg.sv
common/panel_regs_if.sv
src/major_state_seq.sv
front_panel/display_select.sv
front_panel/display_mux.sv
front_panel/readout_port.sv
src/panel_top.sv
dv/panel_properties.sv
dv/panel_tb.sv
